// File: video_pkg.sv
`default_nettype none

package video_pkg;

	// --------------------
	// Pixel and colour types

	// Raster counter, wide enough for 0..319
	typedef logic [8:0] coord_t;

	// Sprite pixel, bit 0 red, bit 1 blue, bit 2 green, zero is transparent
	typedef logic [2:0] pixel_t;

	typedef logic [4:0] colour_t;

	// One pattern row per colour plane
	// r sits in the low byte so the bit order matches pixel_t
	typedef struct packed {
		logic [7:0] g;
		logic [7:0] b;
		logic [7:0] r;
	} plane_t;

	localparam colour_t colour_on = 5'd31;

	// --------------------
	// Raster timing, 320 x 264 at about 5 MHz

	localparam coord_t h_total = 9'd320;
	localparam coord_t v_total = 9'd264;
	localparam coord_t h_visible = 9'd256;
	localparam coord_t v_first = 9'd16;
	localparam coord_t v_last = 9'd240;

	// Sync windows before the centering offset is added
	localparam coord_t hs_base = 9'd280;
	localparam coord_t hs_width = 9'd32;
	localparam coord_t vs_base = 9'd248;
	localparam coord_t vs_width = 9'd4;

	// 49.152 MHz * 89 / 875
	localparam logic [9:0] cen_num = 10'd89;
	localparam logic [9:0] cen_den = 10'd875;

	// --------------------
	// Sprite attribute layout

	localparam int num_sprites = 64;
	localparam logic [7:0] spr_x_offset = 8'd2;
	localparam coord_t spr_y_base = 9'd239;

endpackage

`default_nettype wire

// File: host_pkg.sv
`default_nettype none

package host_pkg;

	// Bus widths
	localparam int bus_addr_w = 16;
	localparam int bus_data_w = 32;
	// Write index into the sprite memories, wide enough for the pattern map
	localparam int idx_w = 12;

	typedef logic [bus_addr_w-1:0] addr_t;
	typedef logic [bus_data_w-1:0] data_t;
	typedef logic [1:0] resp_t;

	// AXI response codes
	localparam resp_t resp_okay = 2'b00;
	localparam resp_t resp_slverr = 2'b10;

	// Address map
	// ctrl word holds h_center in 3..0 and v_center in 7..4
	localparam addr_t ctrl_addr = 16'h0000;
	// 256 attribute bytes, one per word, index in 9..2
	localparam addr_t attr_base = 16'h1000;
	// 4096 pattern rows, one per word, index in 13..2
	localparam addr_t pat_base = 16'h4000;

endpackage

`default_nettype wire

// File: host_wr_if.sv
`timescale 1ns/100ps
`default_nettype none

// Memory writes from the bus slave into the sprite engine
interface host_wr_if import video_pkg::*, host_pkg::*; ();

	// One-cycle strobes, at most one high at a time
	logic attr_we;
	logic pat_we;

	// Attribute writes only look at the low 8 bits
	logic [idx_w-1:0] index;

	// Attribute byte rides in the r field
	plane_t wdata;

	modport host (
		output attr_we,
		output pat_we,
		output index,
		output wdata
	);

	modport engine (
		input attr_we,
		input pat_we,
		input index,
		input wdata
	);

endinterface

`default_nettype wire

// File: video_timing.sv
`timescale 1ns/100ps
`default_nettype none

module video_timing import video_pkg::*; (
	input  logic       clk_49m,
	input  logic       reset,
	input  logic [3:0] h_center_i,
	input  logic [3:0] v_center_i,
	output logic       ce_pix_o,
	output coord_t     h_o,
	output coord_t     v_o,
	output logic       hblank_o,
	output logic       vblank_o,
	output logic       hsync_o,
	output logic       vsync_o,
	output logic       csync_o
);

	logic [9:0]  frac_acc;
	logic [10:0] frac_sum;
	coord_t      hs_start;
	coord_t      vs_start;

	// --------------------
	// Fractional pixel clock enable

	// Add num each clock, pulse and subtract den on overflow
	assign frac_sum = {1'b0, frac_acc} + {1'b0, cen_num};

	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			frac_acc <= '0;
			ce_pix_o <= 1'b0;
		end else if (frac_sum >= {1'b0, cen_den}) begin
			frac_acc <= 10'(frac_sum - {1'b0, cen_den});
			ce_pix_o <= 1'b1;
		end else begin
			frac_acc <= frac_sum[9:0];
			ce_pix_o <= 1'b0;
		end
	end

	// --------------------
	// Raster counters

	// Counters move at the end of the ce_pix cycle
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			h_o <= '0;
			v_o <= '0;
		end else if (ce_pix_o) begin
			if (h_o == h_total - coord_t'(1)) begin
				h_o <= '0;
				v_o <= (v_o == v_total - coord_t'(1)) ? '0 : v_o + coord_t'(1);
			end else begin
				h_o <= h_o + coord_t'(1);
			end
		end
	end

	assign hblank_o = (h_o >= h_visible);
	assign vblank_o = (v_o < v_first) || (v_o >= v_last);

	// Centering shifts both sync windows later
	assign hs_start = hs_base + coord_t'(h_center_i);
	assign vs_start = vs_base + coord_t'(v_center_i);

	assign hsync_o = (h_o >= hs_start) && (h_o < hs_start + hs_width);
	assign vsync_o = (v_o >= vs_start) && (v_o < vs_start + vs_width);
	assign csync_o = ~(hsync_o ^ vsync_o);

endmodule

`default_nettype wire

// File: host_regs.sv
`timescale 1ns/100ps
`default_nettype none

module host_regs import video_pkg::*, host_pkg::*; (
	input  logic       clk_49m,
	input  logic       reset,
	input  addr_t      awaddr_i,
	input  logic       awvalid_i,
	output logic       awready_o,
	input  data_t      wdata_i,
	input  logic       wvalid_i,
	output logic       wready_o,
	output resp_t      bresp_o,
	output logic       bvalid_o,
	input  logic       bready_i,
	input  addr_t      araddr_i,
	input  logic       arvalid_i,
	output logic       arready_o,
	output data_t      rdata_o,
	output resp_t      rresp_o,
	output logic       rvalid_o,
	input  logic       rready_i,
	output logic [3:0] h_center_o,
	output logic [3:0] v_center_o,
	host_wr_if.host    wr
);

	logic wr_accept;
	logic rd_accept;
	logic is_ctrl;
	logic is_attr;
	logic is_pat;

	// Address and data must arrive together, held off while a response waits
	assign awready_o = ~bvalid_o;
	assign wready_o = ~bvalid_o;
	assign arready_o = ~rvalid_o;

	assign wr_accept = awvalid_i & wvalid_i & awready_o & wready_o;
	assign rd_accept = arvalid_i & arready_o;

	// Write address decode
	assign is_ctrl = (awaddr_i == ctrl_addr);
	assign is_attr = (awaddr_i[15:10] == attr_base[15:10]);
	assign is_pat = (awaddr_i[15:14] == pat_base[15:14]);

	// --------------------
	// Write channel

	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			bvalid_o <= 1'b0;
			wr.attr_we <= 1'b0;
			wr.pat_we <= 1'b0;
			h_center_o <= '0;
			v_center_o <= '0;
		end else begin
			// Strobes fire one cycle after acceptance
			wr.attr_we <= wr_accept & is_attr;
			wr.pat_we <= wr_accept & is_pat;
			if (wr_accept) begin
				bvalid_o <= 1'b1;
				if (is_ctrl) begin
					{v_center_o, h_center_o} <= wdata_i[7:0];
				end
			end else if (bready_i) begin
				bvalid_o <= 1'b0;
			end
		end
	end

	// Response code and write payload
	always_ff @(posedge clk_49m) begin
		if (wr_accept) begin
			bresp_o <= (is_ctrl || is_attr || is_pat) ? resp_okay : resp_slverr;
			wr.index <= is_attr ? {4'd0, awaddr_i[9:2]} : awaddr_i[13:2];
			// Attribute byte lands in the r field
			wr.wdata <= plane_t'(wdata_i[23:0]);
		end
	end

	// --------------------
	// Read channel

	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			rvalid_o <= 1'b0;
		end else if (rd_accept) begin
			rvalid_o <= 1'b1;
		end else if (rready_i) begin
			rvalid_o <= 1'b0;
		end
	end

	// Only the centering register reads back, memories are write-only
	always_ff @(posedge clk_49m) begin
		if (rd_accept) begin
			if (araddr_i == ctrl_addr) begin
				rdata_o <= data_t'({v_center_o, h_center_o});
				rresp_o <= resp_okay;
			end else begin
				rdata_o <= '0;
				rresp_o <= resp_slverr;
			end
		end
	end

endmodule

`default_nettype wire

// File: sprite_ram.sv
`timescale 1ns/100ps
`default_nettype none

// Simple dual-port RAM, one write port and one registered read port
module sprite_ram #(
	parameter int addr_w = 8,
	parameter type payload_t = logic [7:0]
) (
	input  logic              clk_49m,
	input  logic              we_i,
	input  logic [addr_w-1:0] waddr_i,
	input  payload_t          wdata_i,
	input  logic [addr_w-1:0] raddr_i,
	output payload_t          rdata_o
);

	payload_t mem [0:(1 << addr_w) - 1];

	always_ff @(posedge clk_49m) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
		// Read data shows up the next cycle
		rdata_o <= mem[raddr_i];
	end

endmodule

`default_nettype wire

// File: sprite_engine.sv
`timescale 1ns/100ps
`default_nettype none

module sprite_engine import video_pkg::*; (
	input  logic      clk_49m,
	input  logic      reset,
	input  logic      ce_pix_i,
	input  coord_t    h_i,
	input  coord_t    v_i,
	host_wr_if.engine wr,
	output colour_t   red_o,
	output colour_t   green_o,
	output colour_t   blue_o
);

	// Each state names the attribute byte that arrives in it
	typedef enum logic [3:0] {
		st_idle, st_clear, st_init, st_ypos, st_flags,
		st_code, st_xpos, st_pixels, st_next
	} scan_state_t;

	localparam logic [5:0] last_sprite = 6'(num_sprites - 1);

	scan_state_t state;
	logic        buf_sel;
	logic [5:0]  spr_idx;
	logic [7:0]  next_line;
	logic [7:0]  clr_addr;
	logic        flip_prev;
	logic        flip_x;
	logic        hit;
	logic [3:0]  row;
	logic [3:0]  row_sel;
	logic [7:0]  x_base;
	logic [2:0]  pix_cnt;
	plane_t      planes;

	logic [7:0]  attr_raddr;
	logic [7:0]  attr_rdata;
	logic [11:0] pat_raddr;
	plane_t      pat_rdata;
	logic        lb_we;
	logic [8:0]  lb_waddr;
	pixel_t      lb_wdata;
	logic [8:0]  lb_raddr;
	pixel_t      lb_rdata;
	logic [8:0]  row_raw;
	logic [2:0]  bit_pos;
	pixel_t      pix_val;

	// --------------------
	// Memories

	sprite_ram #(.addr_w(8), .payload_t(logic [7:0])) attr_ram_i (
		.clk_49m (clk_49m),
		.we_i    (wr.attr_we),
		.waddr_i (wr.index[7:0]),
		.wdata_i (wr.wdata.r),
		.raddr_i (attr_raddr),
		.rdata_o (attr_rdata)
	);

	sprite_ram #(.addr_w(12), .payload_t(plane_t)) pat_ram_i (
		.clk_49m (clk_49m),
		.we_i    (wr.pat_we),
		.waddr_i (wr.index),
		.wdata_i (wr.wdata),
		.raddr_i (pat_raddr),
		.rdata_o (pat_rdata)
	);

	// Both line buffers in one RAM, top address bit picks the buffer
	sprite_ram #(.addr_w(9), .payload_t(pixel_t)) line_buf_i (
		.clk_49m (clk_49m),
		.we_i    (lb_we),
		.waddr_i (lb_waddr),
		.wdata_i (lb_wdata),
		.raddr_i (lb_raddr),
		.rdata_o (lb_rdata)
	);

	// --------------------
	// Scanner datapath

	// Row inside the sprite, a hit when it lands in 0..15
	assign row_raw = {1'b0, next_line} + {1'b0, attr_rdata} - spr_y_base;

	// Code arrives in st_code and goes straight to the pattern address
	assign pat_raddr = {attr_rdata, row_sel};

	// Left pixel comes from bit 7 unless mirrored
	assign bit_pos = flip_x ? pix_cnt : 3'd7 - pix_cnt;
	assign pix_val = {planes.g[bit_pos], planes.b[bit_pos], planes.r[bit_pos]};

	always_comb begin
		case (state)
			// Sprite 63 byte 2 seeds the flip-y of sprite 0
			st_clear:  attr_raddr = {last_sprite, 2'd2};
			st_ypos:   attr_raddr = {spr_idx, 2'd2};
			st_flags:  attr_raddr = {spr_idx, 2'd1};
			st_code:   attr_raddr = {spr_idx, 2'd3};
			st_next:   attr_raddr = {spr_idx + 6'd1, 2'd0};
			default:   attr_raddr = {spr_idx, 2'd0};
		endcase
	end

	// Clear and draw share the write port, both into the back buffer
	assign lb_we = (state == st_clear) || (state == st_pixels && pix_val != '0);
	assign lb_waddr = {~buf_sel, (state == st_clear) ? clr_addr : x_base + {5'd0, pix_cnt}};
	assign lb_wdata = (state == st_clear) ? '0 : pix_val;

	// --------------------
	// Scanner FSM

	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			state <= st_idle;
			buf_sel <= 1'b0;
			spr_idx <= '0;
			clr_addr <= '0;
		end else begin
			// Swap as h wraps to 0
			if (ce_pix_i && h_i == h_total - coord_t'(1)) begin
				buf_sel <= ~buf_sel;
			end
			case (state)
				st_idle: begin
					// Start of hblank, prepare the line shown next
					if (ce_pix_i && h_i == h_visible) begin
						next_line <= 8'(v_i - (v_first - coord_t'(1)));
						clr_addr <= '0;
						spr_idx <= '0;
						state <= st_clear;
					end
				end
				st_clear: begin
					clr_addr <= clr_addr + 8'd1;
					if (clr_addr == 8'hff) begin
						state <= st_init;
					end
				end
				st_init: begin
					flip_prev <= attr_rdata[7];
					state <= st_ypos;
				end
				st_ypos: begin
					hit <= (row_raw[8:4] == '0);
					row <= row_raw[3:0];
					state <= st_flags;
				end
				st_flags: begin
					// flip-y comes from the sprite before, bit 7 goes to the next one
					flip_x <= attr_rdata[6];
					flip_prev <= attr_rdata[7];
					row_sel <= row ^ {4{flip_prev}};
					state <= hit ? st_code : st_next;
				end
				st_code: begin
					state <= st_xpos;
				end
				st_xpos: begin
					x_base <= attr_rdata + spr_x_offset;
					planes <= pat_rdata;
					pix_cnt <= '0;
					state <= st_pixels;
				end
				st_pixels: begin
					pix_cnt <= pix_cnt + 3'd1;
					if (pix_cnt == 3'd7) begin
						state <= st_next;
					end
				end
				st_next: begin
					if (spr_idx == last_sprite) begin
						state <= st_idle;
					end else begin
						spr_idx <= spr_idx + 6'd1;
						state <= st_ypos;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// --------------------
	// Pixel readout

	// Front buffer, data follows h by one clock
	assign lb_raddr = {buf_sel, h_i[7:0]};

	assign red_o = lb_rdata[0] ? colour_on : '0;
	assign blue_o = lb_rdata[1] ? colour_on : '0;
	assign green_o = lb_rdata[2] ? colour_on : '0;

endmodule

`default_nettype wire

// File: sprite_video_top.sv
`timescale 1ns/100ps
`default_nettype none

module sprite_video_top import video_pkg::*, host_pkg::*; (
	input  logic    clk_49m,
	input  logic    reset,
	// AXI4-Lite slave
	input  addr_t   awaddr_i,
	input  logic    awvalid_i,
	output logic    awready_o,
	input  data_t   wdata_i,
	input  logic    wvalid_i,
	output logic    wready_o,
	output resp_t   bresp_o,
	output logic    bvalid_o,
	input  logic    bready_i,
	input  addr_t   araddr_i,
	input  logic    arvalid_i,
	output logic    arready_o,
	output data_t   rdata_o,
	output resp_t   rresp_o,
	output logic    rvalid_o,
	input  logic    rready_i,
	// Video out
	output colour_t red_o,
	output colour_t green_o,
	output colour_t blue_o,
	output logic    hsync_o,
	output logic    vsync_o,
	output logic    csync_o,
	output logic    hblank_o,
	output logic    vblank_o,
	output logic    ce_pix_o
);

	logic [3:0] h_center;
	logic [3:0] v_center;
	coord_t     h_cnt;
	coord_t     v_cnt;
	colour_t    spr_red;
	colour_t    spr_green;
	colour_t    spr_blue;

	host_wr_if wr_bus ();

	video_timing timing_i (
		.clk_49m    (clk_49m),
		.reset      (reset),
		.h_center_i (h_center),
		.v_center_i (v_center),
		.ce_pix_o   (ce_pix_o),
		.h_o        (h_cnt),
		.v_o        (v_cnt),
		.hblank_o   (hblank_o),
		.vblank_o   (vblank_o),
		.hsync_o    (hsync_o),
		.vsync_o    (vsync_o),
		.csync_o    (csync_o)
	);

	host_regs regs_i (
		.clk_49m    (clk_49m),
		.reset      (reset),
		.awaddr_i   (awaddr_i),
		.awvalid_i  (awvalid_i),
		.awready_o  (awready_o),
		.wdata_i    (wdata_i),
		.wvalid_i   (wvalid_i),
		.wready_o   (wready_o),
		.bresp_o    (bresp_o),
		.bvalid_o   (bvalid_o),
		.bready_i   (bready_i),
		.araddr_i   (araddr_i),
		.arvalid_i  (arvalid_i),
		.arready_o  (arready_o),
		.rdata_o    (rdata_o),
		.rresp_o    (rresp_o),
		.rvalid_o   (rvalid_o),
		.rready_i   (rready_i),
		.h_center_o (h_center),
		.v_center_o (v_center),
		.wr         (wr_bus.host)
	);

	sprite_engine engine_i (
		.clk_49m  (clk_49m),
		.reset    (reset),
		.ce_pix_i (ce_pix_o),
		.h_i      (h_cnt),
		.v_i      (v_cnt),
		.wr       (wr_bus.engine),
		.red_o    (spr_red),
		.green_o  (spr_green),
		.blue_o   (spr_blue)
	);

	// Black outside the active area
	assign red_o = (hblank_o | vblank_o) ? '0 : spr_red;
	assign green_o = (hblank_o | vblank_o) ? '0 : spr_green;
	assign blue_o = (hblank_o | vblank_o) ? '0 : spr_blue;

endmodule

`default_nettype wire

// File: tb_sprite_video.sv
`timescale 1ns/100ps
`default_nettype none

module tb_sprite_video import video_pkg::*, host_pkg::*; ();

	localparam int hb_sel = 0;
	localparam int hs_sel = 1;
	localparam int vb_sel = 2;
	localparam int vs_sel = 3;
	localparam int frame_ce = 320 * 264;

	logic    clk_49m;
	logic    reset;
	addr_t   awaddr_i;
	logic    awvalid_i;
	logic    awready_o;
	data_t   wdata_i;
	logic    wvalid_i;
	logic    wready_o;
	resp_t   bresp_o;
	logic    bvalid_o;
	logic    bready_i;
	addr_t   araddr_i;
	logic    arvalid_i;
	logic    arready_o;
	data_t   rdata_o;
	resp_t   rresp_o;
	logic    rvalid_o;
	logic    rready_i;
	colour_t red_o;
	colour_t green_o;
	colour_t blue_o;
	logic    hsync_o;
	logic    vsync_o;
	logic    csync_o;
	logic    hblank_o;
	logic    vblank_o;
	logic    ce_pix_o;

	// Model of the sprite memories, pattern rows laid out g b r from the top
	logic [7:0]  attr_m [0:255];
	logic [23:0] pat_m [0:4095];

	integer seed = 32'h3562;
	string  current_test;
	int     test_errs;
	int     total_errs;
	int     tests_run;
	int     tests_failed;
	logic   frame_chk;
	int     pix_checked;
	int     line_idx;
	int     col_idx;
	logic   prev_hblank;

	sprite_video_top dut_i (.*);

	always #2 clk_49m = ~clk_49m;

	// --------------------
	// Reference model

	// Walk all sprites in order, later non-zero pixels win
	function automatic pixel_t expected_pixel(input int line, input int col);
		pixel_t      px;
		pixel_t      val;
		int          row;
		int          x;
		int          bitn;
		logic        fy;
		logic        fx;
		logic [23:0] pat;
		px = '0;
		for (int s = 0; s < num_sprites; s++) begin
			row = (line + int'(attr_m[s * 4]) - 239) & 511;
			if (row < 16) begin
				// Flip-y sits in the previous sprite, sprite 0 wraps to 63
				fy = attr_m[((s + 63) % 64) * 4 + 2][7];
				fx = attr_m[s * 4 + 2][6];
				if (fy) begin
					row = 15 - row;
				end
				pat = pat_m[int'(attr_m[s * 4 + 1]) * 16 + row];
				for (int i = 0; i < 8; i++) begin
					x = (int'(attr_m[s * 4 + 3]) + 2 + i) & 255;
					bitn = fx ? i : 7 - i;
					val = {pat[16 + bitn], pat[8 + bitn], pat[bitn]};
					if (x == col && val != '0) begin
						px = val;
					end
				end
			end
		end
		return px;
	endfunction

	// --------------------
	// Compare process, one sample per pixel clock

	always @(negedge clk_49m) begin
		pixel_t        px;
		logic [14:0]   exp_rgb;
		if (reset && ce_pix_o) begin
			if (hblank_o || vblank_o) begin
				assert (red_o == '0 && green_o == '0 && blue_o == '0) else begin
					$display("error %s: expected %h actual %h", current_test, 15'd0,
						{red_o, green_o, blue_o});
					test_errs++;
				end
			end
			// Position counted from the blanking edges
			if (vblank_o) begin
				line_idx = 0;
				col_idx = 0;
			end else if (hblank_o) begin
				if (!prev_hblank) begin
					line_idx++;
				end
				col_idx = 0;
			end else begin
				if (frame_chk) begin
					px = expected_pixel(line_idx, col_idx);
					exp_rgb = {px[0] ? colour_on : 5'd0, px[2] ? colour_on : 5'd0,
						px[1] ? colour_on : 5'd0};
					assert ({red_o, green_o, blue_o} == exp_rgb) else begin
						$display("error %s: expected %h actual %h", current_test, exp_rgb,
							{red_o, green_o, blue_o});
						test_errs++;
					end
					pix_checked++;
				end
				col_idx++;
			end
			prev_hblank = hblank_o;
		end
	end

	// --------------------
	// Waits and bus tasks

	task automatic abort_run(input string what);
		$display("timeout waiting for %s in test %s", what, current_test);
		$display("sim failed");
		$finish;
	endtask

	task automatic wait_ce();
		int n;
		n = 0;
		@(negedge clk_49m);
		while (!ce_pix_o) begin
			n++;
			if (n > 64) begin
				abort_run("pixel clock enable");
			end
			@(negedge clk_49m);
		end
	endtask

	// Count pixel clocks until the selected signal shows the level
	task automatic count_ce_until(input int sel, input logic level, input int limit,
		output int n);
		logic cur;
		n = 0;
		do begin
			wait_ce();
			n++;
			cur = (sel == hb_sel) ? hblank_o : (sel == hs_sel) ? hsync_o :
				(sel == vs_sel) ? vsync_o : vblank_o;
			if (n > limit) begin
				abort_run("raster edge");
			end
		end while (cur != level);
	endtask

	task automatic bus_write(input addr_t addr, input data_t data, output resp_t resp);
		int n;
		@(posedge clk_49m);
		#1;
		awaddr_i = addr;
		wdata_i = data;
		awvalid_i = 1'b1;
		wvalid_i = 1'b1;
		bready_i = 1'b1;
		n = 0;
		@(negedge clk_49m);
		while (!(awready_o && wready_o)) begin
			n++;
			if (n > 100) begin
				abort_run("write ready");
			end
			@(negedge clk_49m);
		end
		@(posedge clk_49m);
		#1;
		awvalid_i = 1'b0;
		wvalid_i = 1'b0;
		n = 0;
		@(negedge clk_49m);
		while (!bvalid_o) begin
			n++;
			if (n > 100) begin
				abort_run("write response");
			end
			@(negedge clk_49m);
		end
		resp = bresp_o;
		@(posedge clk_49m);
		#1;
	endtask

	task automatic bus_read(input addr_t addr, output data_t data, output resp_t resp);
		int n;
		@(posedge clk_49m);
		#1;
		araddr_i = addr;
		arvalid_i = 1'b1;
		rready_i = 1'b1;
		n = 0;
		@(negedge clk_49m);
		while (!arready_o) begin
			n++;
			if (n > 100) begin
				abort_run("read ready");
			end
			@(negedge clk_49m);
		end
		@(posedge clk_49m);
		#1;
		arvalid_i = 1'b0;
		n = 0;
		@(negedge clk_49m);
		while (!rvalid_o) begin
			n++;
			if (n > 100) begin
				abort_run("read data");
			end
			@(negedge clk_49m);
		end
		data = rdata_o;
		resp = rresp_o;
		@(posedge clk_49m);
		#1;
	endtask

	task automatic check_value(input int expected, input int actual);
		assert (expected == actual) else begin
			$display("error %s: expected %0h actual %0h", current_test, expected, actual);
			test_errs++;
		end
	endtask

	task automatic write_expect(input addr_t addr, input data_t data, input resp_t exp);
		resp_t resp;
		bus_write(addr, data, resp);
		check_value(int'(exp), int'(resp));
	endtask

	task automatic set_attr(input int s, input int b, input int val);
		attr_m[s * 4 + b] = 8'(val);
		write_expect(addr_t'(int'(attr_base) + (s * 4 + b) * 4), data_t'(val & 255), resp_okay);
	endtask

	task automatic place_sprite(input int s, input int code, input int y, input int x,
		input int flags);
		set_attr(s, 0, y);
		set_attr(s, 1, code);
		set_attr(s, 2, flags);
		set_attr(s, 3, x);
	endtask

	// Random rows, the mask clears whole pixel columns
	task automatic load_code(input int code, input logic [7:0] mask);
		logic [23:0] p;
		for (int r = 0; r < 16; r++) begin
			p = 24'($random(seed)) & {3{mask}};
			pat_m[code * 16 + r] = p;
			write_expect(addr_t'(int'(pat_base) + (code * 16 + r) * 4), data_t'(p), resp_okay);
		end
	endtask

	// One full frame of visible pixels against the model
	task automatic check_frame();
		int n;
		count_ce_until(vb_sel, 1'b1, frame_ce + 10, n);
		pix_checked = 0;
		frame_chk = 1'b1;
		count_ce_until(vb_sel, 1'b0, frame_ce + 10, n);
		count_ce_until(vb_sel, 1'b1, frame_ce + 10, n);
		frame_chk = 1'b0;
		assert (pix_checked == 256 * 224) else begin
			$display("frame check in %s covered only %0d pixels", current_test, pix_checked);
			test_errs++;
		end
	endtask

	task automatic start_test(input string name);
		current_test = name;
		test_errs = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		total_errs += test_errs;
		if (test_errs == 0) begin
			$display("test %s: ok", current_test);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", current_test, test_errs);
		end
	endtask

	// --------------------
	// Test sequence

	initial begin
		data_t rd;
		resp_t rs;
		int    n;
		int    total;
		int    vs_len;
		int    y;
		int    x;
		int    t;
		clk_49m = 1'b0;
		reset = 1'b0;
		awaddr_i = '0;
		awvalid_i = 1'b0;
		wdata_i = '0;
		wvalid_i = 1'b0;
		bready_i = 1'b0;
		araddr_i = '0;
		arvalid_i = 1'b0;
		rready_i = 1'b0;
		frame_chk = 1'b0;
		prev_hblank = 1'b0;
		line_idx = 0;
		col_idx = 0;
		total_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		current_test = "reset";
		for (int i = 0; i < 4096; i++) begin
			pat_m[i] = '0;
		end
		repeat (5) @(posedge clk_49m);
		#1;
		reset = 1'b1;

		start_test("registers");
		write_expect(ctrl_addr, 32'h35, resp_okay);
		bus_read(ctrl_addr, rd, rs);
		check_value(32'h35, int'(rd));
		check_value(int'(resp_okay), int'(rs));
		bus_read(attr_base, rd, rs);
		check_value(0, int'(rd));
		check_value(int'(resp_slverr), int'(rs));
		write_expect(16'h2000, 32'h77, resp_slverr);
		bus_read(ctrl_addr, rd, rs);
		check_value(32'h35, int'(rd));
		finish_test();

		start_test("raster");
		// Line 16 opens the visible area
		count_ce_until(vb_sel, 1'b1, frame_ce + 10, n);
		count_ce_until(vb_sel, 1'b0, frame_ce + 10, n);
		count_ce_until(hb_sel, 1'b1, 400, n);
		total = n;
		count_ce_until(hs_sel, 1'b1, 400, n);
		// h_center is 5 after the register test
		check_value(24 + 5, n);
		check_value(0, int'(csync_o));
		total += n;
		count_ce_until(hs_sel, 1'b0, 400, n);
		check_value(32, n);
		check_value(1, int'(csync_o));
		total += n;
		count_ce_until(hb_sel, 1'b0, 400, n);
		total += n;
		check_value(320, total);
		// Rest of the frame, v_center is 3 so vsync starts 11 lines into vblank
		count_ce_until(vb_sel, 1'b1, frame_ce + 10, n);
		total += n;
		count_ce_until(vs_sel, 1'b1, frame_ce + 10, n);
		check_value((8 + 3) * 320, n);
		check_value(0, int'(csync_o));
		total += n;
		count_ce_until(hs_sel, 1'b1, 400, n);
		check_value(1, int'(csync_o));
		vs_len = n;
		total += n;
		count_ce_until(vs_sel, 1'b0, frame_ce + 10, n);
		check_value(1, int'(csync_o));
		vs_len += n;
		check_value(4 * 320, vs_len);
		total += n;
		count_ce_until(vb_sel, 1'b0, frame_ce + 10, n);
		total += n;
		check_value(frame_ce, total);
		finish_test();

		// Park every sprite where no line can hit it
		start_test("single sprite");
		for (int s = 0; s < num_sprites; s++) begin
			place_sprite(s, 0, 255, 0, 0);
		end
		t = $random(seed) & 255;
		y = 40 + ($random(seed) & 127);
		x = $random(seed) & 255;
		load_code(t, 8'hff);
		place_sprite(5, t, y, x, 0);
		check_frame();
		finish_test();

		start_test("flips");
		t = $random(seed) & 255;
		load_code(t, 8'hff);
		// Sprite 5 hands flip-y to sprite 6, which also mirrors in x
		set_attr(5, 2, 8'h80);
		place_sprite(6, t, y + 20, $random(seed) & 255, 8'h40);
		t = $random(seed) & 255;
		load_code(t, 8'hff);
		place_sprite(0, t, 60 + ($random(seed) & 63), $random(seed) & 255, 0);
		set_attr(63, 2, 8'h80);
		check_frame();
		finish_test();

		start_test("overlap");
		t = $random(seed) & 255;
		load_code(t, 8'hff);
		y = 50 + ($random(seed) & 63);
		x = $random(seed) & 127;
		place_sprite(10, t, y, x, 0);
		t = $random(seed) & 255;
		// Cleared columns let sprite 10 show through
		load_code(t, 8'h5a);
		place_sprite(11, t, y + 4, x + 3, 0);
		check_frame();
		finish_test();

		start_test("back-pressure");
		attr_m[11 * 4 + 3] = 8'(x + 5);
		@(posedge clk_49m);
		#1;
		bready_i = 1'b0;
		awaddr_i = addr_t'(int'(attr_base) + (11 * 4 + 3) * 4);
		wdata_i = data_t'(x + 5);
		awvalid_i = 1'b1;
		wvalid_i = 1'b1;
		n = 0;
		@(negedge clk_49m);
		while (!(awready_o && wready_o)) begin
			n++;
			if (n > 100) begin
				abort_run("first write ready");
			end
			@(negedge clk_49m);
		end
		@(posedge clk_49m);
		#1;
		awaddr_i = ctrl_addr;
		wdata_i = 32'h47;
		// Response held, second write must stay waiting
		for (int i = 0; i < 10; i++) begin
			@(negedge clk_49m);
			assert (bvalid_o && !awready_o && !wready_o) else begin
				$display("second write was accepted while the first response was pending");
				test_errs++;
			end
		end
		check_value(int'(resp_okay), int'(bresp_o));
		@(posedge clk_49m);
		#1;
		bready_i = 1'b1;
		n = 0;
		@(negedge clk_49m);
		while (!(awready_o && wready_o)) begin
			n++;
			if (n > 100) begin
				abort_run("second write ready");
			end
			@(negedge clk_49m);
		end
		@(posedge clk_49m);
		#1;
		awvalid_i = 1'b0;
		wvalid_i = 1'b0;
		n = 0;
		@(negedge clk_49m);
		while (!bvalid_o) begin
			n++;
			if (n > 100) begin
				abort_run("second write response");
			end
			@(negedge clk_49m);
		end
		check_value(int'(resp_okay), int'(bresp_o));
		@(posedge clk_49m);
		#1;
		bus_read(ctrl_addr, rd, rs);
		check_value(32'h47, int'(rd));
		check_frame();
		finish_test();

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
		if (total_errs == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
video_pkg.sv
host_pkg.sv
host_wr_if.sv
video_timing.sv
host_regs.sv
sprite_ram.sv
sprite_engine.sv
sprite_video_top.sv
tb_sprite_video.sv

// File: Makefile
SRCS := $(shell cat verilog.f)

.PHONY: run clean

run: obj_dir/Vtb_sprite_video
	./obj_dir/Vtb_sprite_video | tee /dev/stderr | grep -q "sim passed"

obj_dir/Vtb_sprite_video: verilog.f $(SRCS)
	verilator --binary --timing --top-module tb_sprite_video -f verilog.f -o Vtb_sprite_video

clean:
	rm -rf obj_dir
